/* logic/commit_pkg.sv */
//--------------------------------------------------------------------------
// shared widths for the commit stage
// functional unit and operation encodings, CSR no-op code
//--------------------------------------------------------------------------

package commit_pkg;

  // datapath width
  localparam int unsigned XLEN = 32;
  // integer register address width
  localparam int unsigned REG_ADDR_W = 5;
  // trap cause width
  localparam int unsigned CAUSE_W = 5;
  // operation code width
  localparam int unsigned OP_W = 4;

  //--------------------------------------------------------------------------
  // functional units
  //--------------------------------------------------------------------------
  typedef enum logic [2:0] {
    ALU        = 3'd0,
    LOAD       = 3'd1,
    STORE      = 3'd2,
    CSR        = 3'd3,
    CTRL_FLOW  = 3'd4,
    FENCE_UNIT = 3'd5
  } fu_t;

  //--------------------------------------------------------------------------
  // operations seen at commit
  //--------------------------------------------------------------------------
  // ADD doubles as the CSR no-op
  typedef enum logic [OP_W-1:0] {
    ADD       = 4'd0,
    CSR_WRITE = 4'd1,
    CSR_SET   = 4'd2,
    CSR_CLEAR = 4'd3,
    FENCE     = 4'd4,
    FENCE_I   = 4'd5,
    OTHER     = 4'd15
  } op_t;

  // presented to the CSR file while no CSR instruction retires
  localparam op_t CSR_NOP = ADD;

endpackage

/* logic/store_credit_counter.sv */
//--------------------------------------------------------------------------
// store buffer credit counter
// tracks free store buffer slots, flags stall and drained buffer
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module store_credit_counter #(
  parameter int unsigned StoreBufDepth = 4
) (
  input  logic clk_i,
  input  logic reset_i,
  // one credit leaves with each committed store
  input  logic spend_i,
  // lsu hands one credit back per drained store
  input  logic return_i,
  output logic credit_avail_o,
  output logic buf_empty_o
);

  // wide enough to hold the full depth itself
  localparam int unsigned cnt_width = $clog2(StoreBufDepth + 1);
  localparam logic [cnt_width-1:0] full_count = cnt_width'(StoreBufDepth);

  logic [cnt_width-1:0] count_q;

  // spend and return in the same cycle cancel out
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_q <= full_count;
    end else begin
      case ({spend_i, return_i})
        2'b10:   count_q <= count_q - 1'b1;
        2'b01:   count_q <= count_q + 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // zero credits is the back-pressure condition
  assign credit_avail_o = (count_q != '0);
  // all credits home means no store is pending
  assign buf_empty_o    = (count_q == full_count);

  //--------------------------------------------------------------------------
  // checks against retire logic and lsu
  //--------------------------------------------------------------------------
  // retire must stall a store while no credit is left
  a_no_spend_at_zero : assert property (
    @(posedge clk_i) disable iff (reset_i) spend_i |-> credit_avail_o
  ) else $error("store committed with no credit left");

  // lsu cannot return a credit it never received
  a_no_return_at_full : assert property (
    @(posedge clk_i) disable iff (reset_i) return_i |-> !buf_empty_o
  ) else $error("credit returned while all credits are home");

endmodule

/* logic/fence_sequencer.sv */
//--------------------------------------------------------------------------
// fence sequencer FSM
// drains the store buffer, requests the flush, signals completion
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module fence_sequencer (
  input  logic clk_i,
  input  logic reset_i,
  // a fence entry waits at the head
  input  logic fence_req_i,
  // high for FENCE.I, low for FENCE
  input  logic fence_is_i_i,
  input  logic store_buf_empty_i,
  // one-cycle acknowledge from the controller
  input  logic flush_ack_i,
  output logic fence_o,
  output logic fence_i_o,
  // one-cycle pulse that lets the fence entry retire
  output logic fence_done_o
);

  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    DRAIN = 2'd1,
    FLUSH = 2'd2,
    DONE  = 2'd3
  } state_e;

  state_e state_q;
  state_e state_d;
  // fence kind captured on entry to DRAIN
  logic   is_i_q;

  //--------------------------------------------------------------------------
  // next state
  //--------------------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (fence_req_i) begin
          state_d = DRAIN;
        end
      end
      // committed stores must reach memory before the flush
      DRAIN: begin
        if (store_buf_empty_i) begin
          state_d = FLUSH;
        end
      end
      // hold the request until the controller answers
      FLUSH: begin
        if (flush_ack_i) begin
          state_d = DONE;
        end
      end
      DONE: state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= IDLE;
      is_i_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == IDLE && fence_req_i) begin
        is_i_q <= fence_is_i_i;
      end
    end
  end

  // request only while flushing and routed by the latched kind
  assign fence_o      = (state_q == FLUSH) && !is_i_q;
  assign fence_i_o    = (state_q == FLUSH) && is_i_q;
  assign fence_done_o = (state_q == DONE);

  a_single_flush_kind : assert property (
    @(posedge clk_i) disable iff (reset_i) !(fence_o && fence_i_o)
  ) else $error("fence and fence.i requested together");

endmodule

/* logic/retire_ctrl.sv */
//--------------------------------------------------------------------------
// retire control for the scoreboard head
// acknowledge, register writeback, store, CSR and fence commit
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module retire_ctrl (
  input  logic                                 clk_i,
  input  logic                                 reset_i,
  // scoreboard head
  input  logic                                 head_valid_i,
  input  commit_pkg::fu_t                      head_fu_i,
  input  commit_pkg::op_t                      head_op_i,
  input  logic [commit_pkg::REG_ADDR_W-1:0]    head_rd_i,
  input  logic [commit_pkg::XLEN-1:0]          head_result_i,
  input  logic                                 head_ex_valid_i,
  input  logic                                 halt_i,
  // CSR file answers combinationally
  input  logic [commit_pkg::XLEN-1:0]          csr_rdata_i,
  input  logic                                 csr_ex_valid_i,
  input  logic                                 store_credit_avail_i,
  input  logic                                 fence_done_i,
  output logic                                 commit_ack_o,
  output logic                                 we_o,
  output logic [commit_pkg::REG_ADDR_W-1:0]    waddr_o,
  output logic [commit_pkg::XLEN-1:0]          wdata_o,
  output commit_pkg::op_t                      csr_op_o,
  output logic [commit_pkg::XLEN-1:0]          csr_wdata_o,
  output logic                                 commit_csr_o,
  output logic                                 commit_lsu_o,
  output logic                                 fence_req_o,
  output logic                                 fence_is_i_o
);

  logic committable;

  // no entry exception and no halt request
  assign committable = head_valid_i && !head_ex_valid_i && !halt_i;

  //--------------------------------------------------------------------------
  // commit decision
  //--------------------------------------------------------------------------
  always_comb begin
    commit_ack_o = 1'b0;
    wdata_o      = head_result_i;
    csr_op_o     = commit_pkg::CSR_NOP;
    csr_wdata_o  = '0;
    commit_csr_o = 1'b0;
    commit_lsu_o = 1'b0;
    fence_req_o  = 1'b0;

    if (committable) begin
      case (head_fu_i)
        // a store needs a free slot in the store buffer
        commit_pkg::STORE: begin
          if (store_credit_avail_i) begin
            commit_ack_o = 1'b1;
            commit_lsu_o = 1'b1;
          end
        end
        // CSR read data replaces the result on writeback
        commit_pkg::CSR: begin
          csr_op_o    = head_op_i;
          csr_wdata_o = head_result_i;
          if (!csr_ex_valid_i) begin
            commit_csr_o = 1'b1;
            commit_ack_o = 1'b1;
            wdata_o      = csr_rdata_i;
          end
        end
        // wait for the sequencer to finish drain and flush
        commit_pkg::FENCE_UNIT: begin
          fence_req_o  = 1'b1;
          commit_ack_o = fence_done_i;
        end
        // alu, load and control flow retire at once
        default: begin
          commit_ack_o = 1'b1;
        end
      endcase
    end
  end

  // FENCE.I also flushes the instruction cache
  assign fence_is_i_o = (head_op_i == commit_pkg::FENCE_I);

  // writeback goes with every retirement
  assign we_o    = commit_ack_o;
  assign waddr_o = head_rd_i;

  // a store reaches the buffer only when the head really retires
  a_lsu_with_ack : assert property (
    @(posedge clk_i) disable iff (reset_i) commit_lsu_o |-> commit_ack_o
  ) else $error("store committed without acknowledge");

endmodule

/* logic/exception_select.sv */
//--------------------------------------------------------------------------
// trap selection at commit
// entry exception over CSR exception, both masked by halt
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module exception_select (
  input  logic                              head_valid_i,
  input  logic                              head_ex_valid_i,
  input  logic [commit_pkg::CAUSE_W-1:0]    head_ex_cause_i,
  input  logic [commit_pkg::XLEN-1:0]       head_ex_tval_i,
  input  logic                              csr_ex_valid_i,
  input  logic [commit_pkg::CAUSE_W-1:0]    csr_ex_cause_i,
  input  logic                              halt_i,
  output logic                              exception_valid_o,
  output logic [commit_pkg::CAUSE_W-1:0]    exception_cause_o,
  output logic [commit_pkg::XLEN-1:0]       exception_tval_o
);

  always_comb begin
    exception_valid_o = 1'b0;
    exception_cause_o = '0;
    exception_tval_o  = '0;

    // only a valid head can trap
    if (head_valid_i) begin
      // CSR fault keeps the entry tval, it carries the instruction bits
      if (csr_ex_valid_i) begin
        exception_valid_o = 1'b1;
        exception_cause_o = csr_ex_cause_i;
        exception_tval_o  = head_ex_tval_i;
      end
      // earlier faults, e.g. fetch page faults, take precedence
      if (head_ex_valid_i) begin
        exception_valid_o = 1'b1;
        exception_cause_o = head_ex_cause_i;
        exception_tval_o  = head_ex_tval_i;
      end
    end

    // halted core takes no trap
    if (halt_i) begin
      exception_valid_o = 1'b0;
    end
  end

endmodule

/* logic/commit_stage.sv */
//--------------------------------------------------------------------------
// commit stage top level, single commit port
// credit counter, fence sequencer, retire control, trap select
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module commit_stage #(
  parameter int unsigned StoreBufDepth = 4
) (
  input  logic                              clk_i,
  input  logic                              reset_i,
  // scoreboard head, held until acknowledged
  input  logic                              head_valid_i,
  input  commit_pkg::fu_t                   head_fu_i,
  input  commit_pkg::op_t                   head_op_i,
  input  logic [commit_pkg::REG_ADDR_W-1:0] head_rd_i,
  input  logic [commit_pkg::XLEN-1:0]       head_result_i,
  input  logic [commit_pkg::XLEN-1:0]       head_pc_i,
  input  logic                              head_ex_valid_i,
  input  logic [commit_pkg::CAUSE_W-1:0]    head_ex_cause_i,
  input  logic [commit_pkg::XLEN-1:0]       head_ex_tval_i,
  output logic                              commit_ack_o,
  // integer register file
  output logic                              we_o,
  output logic [commit_pkg::REG_ADDR_W-1:0] waddr_o,
  output logic [commit_pkg::XLEN-1:0]       wdata_o,
  // CSR file
  output commit_pkg::op_t                   csr_op_o,
  output logic [commit_pkg::XLEN-1:0]       csr_wdata_o,
  input  logic [commit_pkg::XLEN-1:0]       csr_rdata_i,
  input  logic                              csr_ex_valid_i,
  input  logic [commit_pkg::CAUSE_W-1:0]    csr_ex_cause_i,
  output logic                              commit_csr_o,
  // store buffer credits
  output logic                              commit_lsu_o,
  input  logic                              lsu_credit_i,
  // controller
  output logic                              fence_o,
  output logic                              fence_i_o,
  input  logic                              flush_ack_i,
  input  logic                              halt_i,
  // trap report
  output logic                              exception_valid_o,
  output logic [commit_pkg::CAUSE_W-1:0]    exception_cause_o,
  output logic [commit_pkg::XLEN-1:0]       exception_tval_o,
  output logic [commit_pkg::XLEN-1:0]       pc_o
);

  logic store_credit_avail;
  logic store_buf_empty;
  logic store_spend;
  logic fence_req;
  logic fence_is_i;
  logic fence_done;

  // the store commit itself spends the credit
  assign commit_lsu_o = store_spend;
  assign pc_o         = head_pc_i;

  store_credit_counter #(
    .StoreBufDepth(StoreBufDepth)
  ) i_store_credit_counter (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .spend_i       (store_spend),
    .return_i      (lsu_credit_i),
    .credit_avail_o(store_credit_avail),
    .buf_empty_o   (store_buf_empty)
  );

  fence_sequencer i_fence_sequencer (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .fence_req_i      (fence_req),
    .fence_is_i_i     (fence_is_i),
    .store_buf_empty_i(store_buf_empty),
    .flush_ack_i      (flush_ack_i),
    .fence_o          (fence_o),
    .fence_i_o        (fence_i_o),
    .fence_done_o     (fence_done)
  );

  retire_ctrl i_retire_ctrl (
    .clk_i               (clk_i),
    .reset_i             (reset_i),
    .head_valid_i        (head_valid_i),
    .head_fu_i           (head_fu_i),
    .head_op_i           (head_op_i),
    .head_rd_i           (head_rd_i),
    .head_result_i       (head_result_i),
    .head_ex_valid_i     (head_ex_valid_i),
    .halt_i              (halt_i),
    .csr_rdata_i         (csr_rdata_i),
    .csr_ex_valid_i      (csr_ex_valid_i),
    .store_credit_avail_i(store_credit_avail),
    .fence_done_i        (fence_done),
    .commit_ack_o        (commit_ack_o),
    .we_o                (we_o),
    .waddr_o             (waddr_o),
    .wdata_o             (wdata_o),
    .csr_op_o            (csr_op_o),
    .csr_wdata_o         (csr_wdata_o),
    .commit_csr_o        (commit_csr_o),
    .commit_lsu_o        (store_spend),
    .fence_req_o         (fence_req),
    .fence_is_i_o        (fence_is_i)
  );

  exception_select i_exception_select (
    .head_valid_i     (head_valid_i),
    .head_ex_valid_i  (head_ex_valid_i),
    .head_ex_cause_i  (head_ex_cause_i),
    .head_ex_tval_i   (head_ex_tval_i),
    .csr_ex_valid_i   (csr_ex_valid_i),
    .csr_ex_cause_i   (csr_ex_cause_i),
    .halt_i           (halt_i),
    .exception_valid_o(exception_valid_o),
    .exception_cause_o(exception_cause_o),
    .exception_tval_o (exception_tval_o)
  );

endmodule

/* dv/tb_clock_gen.sv */
//--------------------------------------------------------------------------
// testbench clock and reset
// 8 ns clock, reset held high for the first 16 cycles
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  // release on a falling edge, like every other DUT input
  initial begin
    reset_o = 1'b1;
    repeat (16) @(posedge clk_o);
    @(negedge clk_o);
    reset_o = 1'b0;
  end

endmodule

/* dv/commit_tb.sv */
//--------------------------------------------------------------------------
// commit stage testbench
// scoreboard, store buffer, CSR file and controller models
// stimulus on the falling edge and checks on the rising edge
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module commit_tb;

  localparam int StoreBufDepth = 4;
  localparam int NumEntries    = 2000;
  localparam int MaxWait       = 300;

  logic                              clk_i;
  logic                              reset_i;
  // scoreboard head
  logic                              head_valid_i;
  commit_pkg::fu_t                   head_fu_i;
  commit_pkg::op_t                   head_op_i;
  logic [commit_pkg::REG_ADDR_W-1:0] head_rd_i;
  logic [commit_pkg::XLEN-1:0]       head_result_i, head_pc_i, head_ex_tval_i;
  logic                              head_ex_valid_i;
  logic [commit_pkg::CAUSE_W-1:0]    head_ex_cause_i;
  logic                              commit_ack_o;
  // register file and CSR file
  logic                              we_o;
  logic [commit_pkg::REG_ADDR_W-1:0] waddr_o;
  logic [commit_pkg::XLEN-1:0]       wdata_o, csr_wdata_o, csr_rdata_i;
  commit_pkg::op_t                   csr_op_o;
  logic                              csr_ex_valid_i, commit_csr_o;
  logic [commit_pkg::CAUSE_W-1:0]    csr_ex_cause_i;
  // store buffer, controller and trap
  logic                              commit_lsu_o, lsu_credit_i;
  logic                              fence_o, fence_i_o, flush_ack_i, halt_i;
  logic                              exception_valid_o;
  logic [commit_pkg::CAUSE_W-1:0]    exception_cause_o;
  logic [commit_pkg::XLEN-1:0]       exception_tval_o, pc_o;

  // stores committed but not yet drained by the store buffer model
  int          credits_out;
  logic        fence_prev, flush_prev;
  logic        committable;
  // corner cases the random stimulus has to hit
  int unsigned stall_hits = 0;
  int unsigned prio_hits = 0;
  int unsigned fence_i_hits = 0;

  tb_clock_gen i_clock_gen (
    .clk_o  (clk_i),
    .reset_o(reset_i)
  );

  commit_stage #(
    .StoreBufDepth(StoreBufDepth)
  ) i_commit_stage (.*);

  task automatic abort_run();
    $display("test failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    assert (got === expected) else begin
      $display("FAIL %s: got 0x%h, expected 0x%h", name, got, expected);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic expected);
    assert (got === expected) else begin
      $display("FAIL %s: got 0x%h, expected 0x%h", name, got, expected);
      abort_run();
    end
  endtask

  // new random head entry with a matching CSR file answer
  task automatic drive_entry();
    int unsigned pick;
    pick = $urandom_range(5);
    head_valid_i = 1'b1;
    head_fu_i    = commit_pkg::fu_t'(pick);
    case (head_fu_i)
      commit_pkg::CSR:        head_op_i = commit_pkg::op_t'($urandom_range(3, 1));
      commit_pkg::FENCE_UNIT: head_op_i = ($urandom_range(1) != 0) ? commit_pkg::FENCE_I
                                                                    : commit_pkg::FENCE;
      default:                head_op_i = ($urandom_range(1) != 0) ? commit_pkg::OTHER
                                                                    : commit_pkg::ADD;
    endcase
    head_rd_i       = 5'($urandom);
    head_result_i   = $urandom;
    head_pc_i       = $urandom;
    head_ex_valid_i = ($urandom_range(7) == 0);
    head_ex_cause_i = 5'($urandom);
    head_ex_tval_i  = $urandom;
    // a CSR fault only ever belongs to the current entry
    csr_ex_valid_i  = (head_fu_i == commit_pkg::CSR) && ($urandom_range(3) == 0);
    csr_ex_cause_i  = 5'($urandom);
    csr_rdata_i     = $urandom;
  endtask

  assign committable = head_valid_i && !head_ex_valid_i && !halt_i;

  // whether the head should retire in the current cycle
  function automatic logic expected_ack();
    logic ack;
    ack = 1'b0;
    if (committable) begin
      case (head_fu_i)
        commit_pkg::STORE:      ack = (credits_out < StoreBufDepth);
        commit_pkg::CSR:        ack = !csr_ex_valid_i;
        // a fence retires in the cycle right after the flush acknowledge
        commit_pkg::FENCE_UNIT: ack = flush_prev;
        default:                ack = 1'b1;
      endcase
    end
    return ack;
  endfunction

  //--------------------------------------------------------------------------
  // models
  //--------------------------------------------------------------------------
  // store buffer drains one committed store now and then
  initial begin
    lsu_credit_i = 1'b0;
    forever begin
      @(negedge clk_i);
      lsu_credit_i = 1'b0;
      if (credits_out > 0) lsu_credit_i = ($urandom_range(5) == 0);
    end
  end

  // controller answers a flush request after a few cycles
  initial begin
    int unsigned delay;
    flush_ack_i = 1'b0;
    delay       = 2;
    forever begin
      @(negedge clk_i);
      flush_ack_i = 1'b0;
      if (fence_o || fence_i_o) begin
        if (delay == 0) begin
          flush_ack_i = 1'b1;
          delay       = $urandom_range(6);
        end else begin
          delay--;
        end
      end
    end
  end

  // history of credits and flush handshake
  always @(posedge clk_i) begin
    if (reset_i) begin
      credits_out <= 0;
      fence_prev  <= 1'b0;
      flush_prev  <= 1'b0;
    end else begin
      credits_out <= credits_out + int'(commit_lsu_o) - int'(lsu_credit_i);
      fence_prev  <= fence_o || fence_i_o;
      flush_prev  <= flush_ack_i;
    end
  end

  //--------------------------------------------------------------------------
  // checks
  //--------------------------------------------------------------------------
  always @(posedge clk_i) begin
    if (!reset_i) begin
      check_value("pc_o", pc_o, head_pc_i);
      check_flag("commit_ack_o", commit_ack_o, expected_ack());
      check_flag("we_o", we_o, expected_ack());
      check_value("waddr_o", 32'(waddr_o), 32'(head_rd_i));
      // plain retirement writes the result unchanged
      if (committable && (head_fu_i == commit_pkg::ALU || head_fu_i == commit_pkg::LOAD ||
                          head_fu_i == commit_pkg::CTRL_FLOW)) begin
        check_value("wdata_o", wdata_o, head_result_i);
      end
      // stores need a credit
      check_flag("commit_lsu_o", commit_lsu_o, committable &&
                 head_fu_i == commit_pkg::STORE && credits_out < StoreBufDepth);
      if (committable && head_fu_i == commit_pkg::STORE && credits_out >= StoreBufDepth) begin
        stall_hits <= stall_hits + 1;
      end
      // CSR commit swaps in the read data
      check_flag("commit_csr_o", commit_csr_o, committable &&
                 head_fu_i == commit_pkg::CSR && !csr_ex_valid_i);
      if (committable && head_fu_i == commit_pkg::CSR) begin
        check_value("csr_op_o", 32'(csr_op_o), 32'(head_op_i));
        check_value("csr_wdata_o", csr_wdata_o, head_result_i);
        if (!csr_ex_valid_i) check_value("wdata_o", wdata_o, csr_rdata_i);
      end
      if (!head_valid_i || head_fu_i != commit_pkg::CSR)
        check_value("csr_op_o", 32'(csr_op_o), 32'(commit_pkg::CSR_NOP));
      // trap priority with halt masking everything
      check_flag("exception_valid_o", exception_valid_o,
                 head_valid_i && !halt_i && (head_ex_valid_i || csr_ex_valid_i));
      if (head_valid_i && !halt_i && head_ex_valid_i) begin
        check_value("exception_cause_o", 32'(exception_cause_o), 32'(head_ex_cause_i));
        check_value("exception_tval_o", exception_tval_o, head_ex_tval_i);
        if (csr_ex_valid_i) prio_hits <= prio_hits + 1;
      end else if (head_valid_i && !halt_i && csr_ex_valid_i) begin
        check_value("exception_cause_o", 32'(exception_cause_o), 32'(csr_ex_cause_i));
        check_value("exception_tval_o", exception_tval_o, head_ex_tval_i);
      end
      // fence handshake with store buffer and controller
      if ((fence_o || fence_i_o) && !fence_prev) begin
        check_value("commit_lsu_o outstanding at fence request", 32'(credits_out), 0);
        check_flag("fence_i_o", fence_i_o, head_op_i == commit_pkg::FENCE_I);
      end
      if (fence_prev && !flush_prev) begin
        check_flag("fence_o | fence_i_o", fence_o || fence_i_o, 1'b1);
      end
      if (commit_ack_o && head_fu_i == commit_pkg::FENCE_UNIT &&
          head_op_i == commit_pkg::FENCE_I) begin
        fence_i_hits <= fence_i_hits + 1;
      end
    end
  end

  //--------------------------------------------------------------------------
  // scoreboard model and run control
  //--------------------------------------------------------------------------
  initial begin
    int unsigned waited;
    logic        retired;
    void'($urandom(53));
    head_valid_i    = 1'b0;
    head_fu_i       = commit_pkg::ALU;
    head_op_i       = commit_pkg::ADD;
    head_rd_i       = '0;
    head_result_i   = '0;
    head_pc_i       = '0;
    head_ex_valid_i = 1'b0;
    head_ex_cause_i = '0;
    head_ex_tval_i  = '0;
    csr_rdata_i     = '0;
    csr_ex_valid_i  = 1'b0;
    csr_ex_cause_i  = '0;
    halt_i          = 1'b0;
    waited          = 0;
    do begin
      @(posedge clk_i);
      waited++;
      if (waited > 64) begin
        $display("reset was never released");
        abort_run();
      end
    end while (reset_i);
    @(negedge clk_i);
    for (int n = 0; n < NumEntries; n++) begin
      drive_entry();
      retired = 1'b0;
      waited  = 0;
      // hold the entry until it retires or traps
      while (!retired) begin
        @(posedge clk_i);
        retired = commit_ack_o || exception_valid_o;
        @(negedge clk_i);
        halt_i = ($urandom_range(15) == 0);
        waited++;
        if (!retired && waited > MaxWait) begin
          $display("head entry %0d neither retired nor trapped in time", n);
          abort_run();
        end
      end
    end
    if (stall_hits == 0 || prio_hits == 0 || fence_i_hits == 0) begin
      $display("stimulus missed a store stall, a trap priority case or a FENCE.I");
      abort_run();
    end else begin
      $display("test passed");
      $finish;
    end
  end

endmodule

/* compile.f */
logic/commit_pkg.sv
logic/store_credit_counter.sv
logic/fence_sequencer.sv
logic/retire_ctrl.sv
logic/exception_select.sv
logic/commit_stage.sv
dv/tb_clock_gen.sv
dv/commit_tb.sv

/* run.sh */
#!/bin/sh
# build the commit stage testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f compile.f --top-module commit_tb -Mdir obj_dir

./obj_dir/Vcommit_tb
